// ==== filelist.f ====
hw/rv_core_pkg.sv
hw/rv_control_fsm.sv
hw/rv_fetch_decode.sv
hw/rv_register_file.sv
hw/rv_execute.sv
hw/rv_writeback.sv
hw/rv_core_top.sv
verif/rv_core_checker.sv
verif/rv_core_tb.sv

// ==== hw/rv_control_fsm.sv ====
`timescale 1ns/100ps

module rv_control_fsm (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       mem_busy,
    input  logic [1:0]                 addr_low,
    input  rv_core_pkg::decoded_t      dec,
    input  rv_core_pkg::alu_flags_t    flags,
    output rv_core_pkg::datapath_ctrl_t ctrl,
    output logic                       mem_rd_en,
    output logic                       mem_wr_en,
    output rv_core_pkg::byte_en_t      mem_byte_en,
    output logic                       illegal_instruction,
    output logic                       ecall
);
    import rv_core_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;
    logic        branch_taken;
    byte_en_t    size_en;
    byte_en_t    lane_en;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // eq uses zero, signed uses n^v, unsigned uses carry (set when no borrow)
    always_comb begin
        if (dec.funct3[1]) begin
            branch_taken = ~flags.carry_out ^ dec.funct3[0];
        end else if (dec.funct3[2]) begin
            branch_taken = (flags.negative ^ flags.overflow) ^ dec.funct3[0];
        end else begin
            branch_taken = flags.zero ^ dec.funct3[0];
        end
    end

    assign size_en = (dec.funct3[1:0] == 2'b00) ? 4'h1 :
                     (dec.funct3[1:0] == 2'b01) ? 4'h3 : 4'hf;
    assign lane_en = byte_en_t'(size_en << addr_low);

    always_comb begin
        ctrl                = '0;
        mem_rd_en           = 1'b0;
        mem_wr_en           = 1'b0;
        mem_byte_en         = '0;
        illegal_instruction = 1'b0;
        ecall               = 1'b0;
        state_next          = st_fetch;

        case (state)
            st_idle: begin
                state_next = st_fetch;
            end
            st_fetch: begin
                mem_rd_en   = 1'b1;
                mem_byte_en = 4'hf;
                state_next  = mem_busy ? st_fetch_wait : st_fetch;
            end
            st_fetch_wait: begin
                mem_byte_en = 4'hf;
                if (mem_busy) begin
                    mem_rd_en  = 1'b1;
                    state_next = st_fetch_wait;
                end else begin
                    ctrl.ir_en = 1'b1;
                    state_next = st_decode;
                end
            end
            st_decode: begin
                case (dec.opcode)
                    op_reg:    state_next = st_reg_reg;
                    op_imm:    state_next = st_reg_imm;
                    op_lui:    state_next = st_lui;
                    op_auipc:  state_next = st_auipc;
                    op_jal:    state_next = st_jal;
                    op_jalr:   state_next = st_jalr;
                    op_branch: state_next = st_branch;
                    op_load:   state_next = st_load;
                    op_store:  state_next = st_store;
                    op_system: begin
                        // only ecall, ebreak and the rest are rejected
                        if (dec.funct3 == '0 && dec.funct7 == '0 && dec.rs2 == '0) begin
                            state_next = st_ecall;
                        end else begin
                            illegal_instruction = 1'b1;
                        end
                    end
                    default:   illegal_instruction = 1'b1;
                endcase
            end
            st_reg_reg: begin
                ctrl.alu_op     = alu_op_t'(dec.funct3);
                ctrl.sub        = dec.funct7[5];
                ctrl.arithmetic = dec.funct7[5];
                ctrl.pc_en      = 1'b1;
                ctrl.wr_reg_en  = 1'b1;
            end
            st_reg_imm: begin
                ctrl.alub_src   = 1'b1;
                ctrl.alu_op     = alu_op_t'(dec.funct3);
                ctrl.arithmetic = dec.funct7[5] & (dec.funct3 == 3'b101);
                ctrl.pc_en      = 1'b1;
                ctrl.wr_reg_en  = 1'b1;
            end
            st_lui: begin
                // alupc_src without pc_src tells the ALU to zero operand a
                ctrl.alub_src  = 1'b1;
                ctrl.alupc_src = 1'b1;
                ctrl.pc_en     = 1'b1;
                ctrl.wr_reg_en = 1'b1;
            end
            st_auipc: begin
                ctrl.alua_src  = 1'b1;
                ctrl.alub_src  = 1'b1;
                ctrl.pc_en     = 1'b1;
                ctrl.wr_reg_en = 1'b1;
            end
            st_jal: begin
                ctrl.pc_src    = 1'b1;
                ctrl.pc_en     = 1'b1;
                ctrl.wb_src    = wb_pc4;
                ctrl.wr_reg_en = 1'b1;
            end
            st_jalr: begin
                ctrl.alub_src  = 1'b1;
                ctrl.alupc_src = 1'b1;
                ctrl.pc_src    = 1'b1;
                ctrl.pc_en     = 1'b1;
                ctrl.wb_src    = wb_pc4;
                ctrl.wr_reg_en = 1'b1;
            end
            st_branch: begin
                ctrl.sub    = 1'b1;
                ctrl.pc_src = branch_taken;
                ctrl.pc_en  = 1'b1;
            end
            st_load, st_load_wait: begin
                ctrl.mem_addr_src = 1'b1;
                ctrl.alub_src     = 1'b1;
                ctrl.wb_src       = wb_mem;
                mem_byte_en       = lane_en;
                if (state == st_load) begin
                    mem_rd_en  = 1'b1;
                    state_next = mem_busy ? st_load_wait : st_load;
                end else if (mem_busy) begin
                    mem_rd_en  = 1'b1;
                    state_next = st_load_wait;
                end else begin
                    ctrl.pc_en     = 1'b1;
                    ctrl.wr_reg_en = 1'b1;
                end
            end
            st_store, st_store_wait: begin
                ctrl.mem_addr_src = 1'b1;
                ctrl.alub_src     = 1'b1;
                mem_byte_en       = lane_en;
                if (state == st_store) begin
                    mem_wr_en  = 1'b1;
                    state_next = mem_busy ? st_store_wait : st_store;
                end else if (mem_busy) begin
                    mem_wr_en  = 1'b1;
                    state_next = st_store_wait;
                end else begin
                    ctrl.pc_en = 1'b1;
                end
            end
            st_ecall: begin
                ecall = 1'b1;
            end
            default: state_next = st_idle;
        endcase
    end

    a_strobes_exclusive: assert property (
        @(posedge clock) disable iff (reset) !(mem_rd_en && mem_wr_en));

    a_state_known: assert property (
        @(posedge clock) disable iff (reset) !$isunknown(state));

    a_ecall_no_write: assert property (
        @(posedge clock) disable iff (reset) !(ecall && ctrl.wr_reg_en));

endmodule

// ==== hw/rv_core_pkg.sv ====
package rv_core_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  byte_en_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  opcode_t;

    localparam xlen_t reset_pc = 32'h0000_0000;

    // base opcodes, low two bits are always 11
    localparam opcode_t op_load   = 7'b0000011;
    localparam opcode_t op_imm    = 7'b0010011;
    localparam opcode_t op_auipc  = 7'b0010111;
    localparam opcode_t op_store  = 7'b0100011;
    localparam opcode_t op_reg    = 7'b0110011;
    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_branch = 7'b1100011;
    localparam opcode_t op_jalr   = 7'b1100111;
    localparam opcode_t op_jal    = 7'b1101111;
    localparam opcode_t op_system = 7'b1110011;

    // encoded exactly as funct3
    typedef enum logic [2:0] {
        alu_add  = 3'b000,
        alu_sll  = 3'b001,
        alu_slt  = 3'b010,
        alu_sltu = 3'b011,
        alu_xor  = 3'b100,
        alu_srl  = 3'b101,
        alu_or   = 3'b110,
        alu_and  = 3'b111
    } alu_op_t;

    typedef enum logic [1:0] {
        wb_alu = 2'b00,
        wb_mem = 2'b10,
        wb_pc4 = 2'b11
    } wb_src_t;

    typedef enum logic [3:0] {
        st_idle, st_fetch, st_fetch_wait, st_decode,
        st_reg_reg, st_lui, st_reg_imm, st_auipc,
        st_jal, st_branch, st_jalr, st_load,
        st_load_wait, st_store, st_store_wait, st_ecall
    } ctrl_state_t;

    typedef struct packed {
        logic    alua_src;
        logic    alub_src;
        alu_op_t alu_op;
        logic    sub;
        logic    arithmetic;
        logic    alupc_src;
        logic    pc_src;
        logic    pc_en;
        wb_src_t wb_src;
        logic    wr_reg_en;
        logic    ir_en;
        logic    mem_addr_src;
    } datapath_ctrl_t;

    typedef struct packed {
        logic zero;
        logic negative;
        logic carry_out;
        logic overflow;
    } alu_flags_t;

    typedef struct packed {
        opcode_t   opcode;
        funct3_t   funct3;
        logic [6:0] funct7;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        xlen_t     imm;
    } decoded_t;

endpackage

// ==== hw/rv_core_top.sv ====
`timescale 1ns/100ps

module rv_core_top (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  mem_busy,
    input  rv_core_pkg::xlen_t    mem_rdata,
    output rv_core_pkg::xlen_t    mem_addr,
    output rv_core_pkg::xlen_t    mem_wdata,
    output logic                  mem_rd_en,
    output logic                  mem_wr_en,
    output rv_core_pkg::byte_en_t mem_byte_en,
    output logic                  ecall,
    output logic                  illegal_instruction
);
    import rv_core_pkg::*;

    datapath_ctrl_t ctrl;
    alu_flags_t     flags;
    decoded_t       dec;
    xlen_t          pc;
    xlen_t          alu_result;
    xlen_t          byte_addr;
    xlen_t          rs1_data;
    xlen_t          rs2_data;
    xlen_t          wr_data;

    // the port is word aligned, the lane travels in mem_byte_en
    assign mem_addr = {byte_addr[31:2], 2'b00};

    rv_control_fsm u_control_fsm (
        .clock               (clock),
        .reset               (reset),
        .mem_busy            (mem_busy),
        .addr_low            (byte_addr[1:0]),
        .dec                 (dec),
        .flags               (flags),
        .ctrl                (ctrl),
        .mem_rd_en           (mem_rd_en),
        .mem_wr_en           (mem_wr_en),
        .mem_byte_en         (mem_byte_en),
        .illegal_instruction (illegal_instruction),
        .ecall               (ecall)
    );

    rv_fetch_decode u_fetch_decode (
        .clock      (clock),
        .reset      (reset),
        .ctrl       (ctrl),
        .mem_rdata  (mem_rdata),
        .alu_result (alu_result),
        .dec        (dec),
        .pc         (pc)
    );

    rv_register_file u_register_file (
        .clock    (clock),
        .reset    (reset),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .rd       (dec.rd),
        .wr_en    (ctrl.wr_reg_en),
        .wr_data  (wr_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    rv_execute u_execute (
        .ctrl       (ctrl),
        .pc         (pc),
        .imm        (dec.imm),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .alu_result (alu_result),
        .flags      (flags),
        .mem_addr   (byte_addr)
    );

    rv_writeback u_writeback (
        .wb_src     (ctrl.wb_src),
        .funct3     (dec.funct3),
        .addr_low   (byte_addr[1:0]),
        .mem_rdata  (mem_rdata),
        .alu_result (alu_result),
        .pc         (pc),
        .rs2_data   (rs2_data),
        .wr_data    (wr_data),
        .mem_wdata  (mem_wdata)
    );

endmodule

// ==== hw/rv_execute.sv ====
`timescale 1ns/100ps

module rv_execute (
    input  rv_core_pkg::datapath_ctrl_t ctrl,
    input  rv_core_pkg::xlen_t          pc,
    input  rv_core_pkg::xlen_t          imm,
    input  rv_core_pkg::xlen_t          rs1_data,
    input  rv_core_pkg::xlen_t          rs2_data,
    output rv_core_pkg::xlen_t          alu_result,
    output rv_core_pkg::alu_flags_t     flags,
    output rv_core_pkg::xlen_t          mem_addr
);
    import rv_core_pkg::*;

    xlen_t      op_a;
    xlen_t      op_b;
    xlen_t      diff;
    logic       carry;
    logic       lui_zero;
    logic [4:0] shamt;

    // lui is the only state with alupc_src and no pc_src
    assign lui_zero = ctrl.alub_src & ctrl.alupc_src & ~ctrl.pc_src;

    assign op_a  = lui_zero ? '0 : (ctrl.alua_src ? pc : rs1_data);
    assign op_b  = ctrl.alub_src ? imm : rs2_data;
    assign shamt = op_b[4:0];

    // a + ~b + 1, carry set when there is no borrow
    assign {carry, diff} = {1'b0, op_a} + {1'b0, ~op_b} + 33'd1;

    assign flags.zero      = (diff == '0);
    assign flags.negative  = diff[31];
    assign flags.carry_out = carry;
    assign flags.overflow  = (op_a[31] != op_b[31]) && (diff[31] != op_a[31]);

    always_comb begin
        case (ctrl.alu_op)
            alu_add:  alu_result = ctrl.sub ? diff : op_a + op_b;
            alu_sll:  alu_result = op_a << shamt;
            alu_slt:  alu_result = {31'b0, flags.negative ^ flags.overflow};
            alu_sltu: alu_result = {31'b0, ~carry};
            alu_xor:  alu_result = op_a ^ op_b;
            alu_srl:  alu_result = ctrl.arithmetic ? xlen_t'($signed(op_a) >>> shamt)
                                                   : op_a >> shamt;
            alu_or:   alu_result = op_a | op_b;
            default:  alu_result = op_a & op_b;
        endcase
    end

    assign mem_addr = ctrl.mem_addr_src ? alu_result : pc;

endmodule

// ==== hw/rv_fetch_decode.sv ====
`timescale 1ns/100ps

module rv_fetch_decode (
    input  logic                        clock,
    input  logic                        reset,
    input  rv_core_pkg::datapath_ctrl_t ctrl,
    input  rv_core_pkg::xlen_t          mem_rdata,
    input  rv_core_pkg::xlen_t          alu_result,
    output rv_core_pkg::decoded_t       dec,
    output rv_core_pkg::xlen_t          pc
);
    import rv_core_pkg::*;

    instr_t ir;
    xlen_t  jump_target;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (ctrl.pc_en) begin
            pc <= ctrl.pc_src ? jump_target : pc + 32'd4;
        end
    end

    // instruction register, loaded as a fetch completes
    always_ff @(posedge clock) begin
        if (ctrl.ir_en) begin
            ir <= mem_rdata;
        end
    end

    // jalr clears bit 0 of rs1 + imm
    assign jump_target = ctrl.alupc_src ? {alu_result[31:1], 1'b0} : pc + dec.imm;

    assign dec.opcode = ir[6:0];
    assign dec.rd     = ir[11:7];
    assign dec.funct3 = ir[14:12];
    assign dec.rs1    = ir[19:15];
    assign dec.rs2    = ir[24:20];
    assign dec.funct7 = ir[31:25];

    always_comb begin
        case (ir[6:0])
            op_load, op_imm, op_jalr, op_system:
                dec.imm = {{20{ir[31]}}, ir[31:20]};
            op_store:
                dec.imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
            op_branch:
                dec.imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
            op_lui, op_auipc:
                dec.imm = {ir[31:12], 12'h000};
            op_jal:
                dec.imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
            default:
                dec.imm = '0;
        endcase
    end

    a_pc_aligned: assert property (
        @(posedge clock) disable iff (reset) pc[1:0] == 2'b00);

endmodule

// ==== hw/rv_register_file.sv ====
`timescale 1ns/100ps

module rv_register_file (
    input  logic                  clock,
    input  logic                  reset,
    input  rv_core_pkg::reg_addr_t rs1,
    input  rv_core_pkg::reg_addr_t rs2,
    input  rv_core_pkg::reg_addr_t rd,
    input  logic                  wr_en,
    input  rv_core_pkg::xlen_t    wr_data,
    output rv_core_pkg::xlen_t    rs1_data,
    output rv_core_pkg::xlen_t    rs2_data
);
    import rv_core_pkg::*;

    xlen_t regs [32];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && rd != '0) begin
            regs[rd] <= wr_data;
        end
    end

    // x0 never written so it reads back zero
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

endmodule

// ==== hw/rv_writeback.sv ====
`timescale 1ns/100ps

module rv_writeback (
    input  rv_core_pkg::wb_src_t wb_src,
    input  rv_core_pkg::funct3_t funct3,
    input  logic [1:0]           addr_low,
    input  rv_core_pkg::xlen_t   mem_rdata,
    input  rv_core_pkg::xlen_t   alu_result,
    input  rv_core_pkg::xlen_t   pc,
    input  rv_core_pkg::xlen_t   rs2_data,
    output rv_core_pkg::xlen_t   wr_data,
    output rv_core_pkg::xlen_t   mem_wdata
);
    import rv_core_pkg::*;

    xlen_t lane_data;
    xlen_t load_data;
    logic  fill;

    // move the addressed lane down to bit 0
    assign lane_data = mem_rdata >> {addr_low, 3'b000};

    always_comb begin
        case (funct3[1:0])
            2'b00: begin
                fill      = ~funct3[2] & lane_data[7];
                load_data = {{24{fill}}, lane_data[7:0]};
            end
            2'b01: begin
                fill      = ~funct3[2] & lane_data[15];
                load_data = {{16{fill}}, lane_data[15:0]};
            end
            default: begin
                fill      = 1'b0;
                load_data = lane_data;
            end
        endcase
    end

    // byte enables pick the lane, so repeat the data in every lane
    assign mem_wdata = (funct3[1:0] == 2'b00) ? {4{rs2_data[7:0]}} :
                       (funct3[1:0] == 2'b01) ? {2{rs2_data[15:0]}} : rs2_data;

    always_comb begin
        case (wb_src)
            wb_mem:  wr_data = load_data;
            wb_pc4:  wr_data = pc + 32'd4;
            default: wr_data = alu_result;
        endcase
    end

endmodule

// ==== verif/rv_core_checker.sv ====
`timescale 1ns/100ps

module rv_core_checker (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        mem_wr_en,
    input  rv_core_pkg::xlen_t          mem_addr,
    input  rv_core_pkg::byte_en_t       mem_byte_en,
    input  rv_core_pkg::xlen_t          mem_wdata,
    input  logic                        ecall,
    input  logic                        illegal_instruction,
    input  rv_core_pkg::xlen_t [0:3]    exp_addr,
    input  rv_core_pkg::byte_en_t [0:3] exp_be,
    input  rv_core_pkg::xlen_t [0:3]    exp_data,
    input  int                          exp_count,
    input  logic                        exp_illegal,
    output logic                        test_done,
    output int                          error_count
);
    import rv_core_pkg::*;

    // one program gets this many cycles to reach its end pulse
    localparam int cycle_limit = 12 * 40;

    int   errors = 0;
    int   store_idx;
    int   end_seen;
    int   cycles;
    logic wr_prev;

    assign error_count = errors;

    task automatic compare(input string what, input xlen_t got, input xlen_t want);
        if (got !== want) begin
            errors++;
            $display("FAILED %0t: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    always @(posedge clock) begin
        if (reset) begin
            store_idx <= 0;
            end_seen  <= 0;
            cycles    <= 0;
            wr_prev   <= 1'b0;
            test_done <= 1'b0;
        end else if (!test_done) begin
            wr_prev <= mem_wr_en;
            cycles  <= cycles + 1;
            // a store is counted once, on the rise of its strobe
            if (mem_wr_en && !wr_prev) begin
                if (store_idx >= exp_count) begin
                    errors++;
                    $display("%0t: extra store to address %h", $time, mem_addr);
                end else begin
                    compare($sformatf("store %0d address", store_idx), mem_addr,
                            exp_addr[store_idx]);
                    compare($sformatf("store %0d byte enable", store_idx),
                            xlen_t'(mem_byte_en), xlen_t'(exp_be[store_idx]));
                    compare($sformatf("store %0d data", store_idx), mem_wdata,
                            exp_data[store_idx]);
                end
                store_idx <= store_idx + 1;
            end
            if (ecall || illegal_instruction) begin
                if (illegal_instruction !== exp_illegal) begin
                    errors++;
                    $display("FAILED %0t: end event illegal=%b, expected illegal=%b",
                             $time, illegal_instruction, exp_illegal);
                end
                if (end_seen == 0 && store_idx < exp_count) begin
                    errors++;
                    $display("%0t: only %0d of %0d stores seen before the end pulse",
                             $time, store_idx, exp_count);
                end
                // the pc holds, so the same end instruction comes round again
                end_seen <= end_seen + 1;
                if (end_seen == 1) begin
                    test_done <= 1'b1;
                end
            end else if (cycles >= cycle_limit) begin
                errors++;
                $display("%0t: no end pulse within %0d cycles", $time, cycle_limit);
                test_done <= 1'b1;
            end
        end
    end

endmodule

// ==== verif/rv_core_tb.sv ====
`timescale 1ns/100ps

module rv_core_tb;
    import rv_core_pkg::*;

    localparam int     num_tests    = 9;
    localparam int     prog_words   = 12;
    localparam real    clock_period = 8.0;
    localparam instr_t ecall_word   = 32'h0000_0073;

    logic     clock     = 1'b0;
    logic     reset     = 1'b1;
    logic     mem_busy  = 1'b0;
    xlen_t    mem_rdata = '0;
    xlen_t    mem_addr;
    xlen_t    mem_wdata;
    logic     mem_rd_en;
    logic     mem_wr_en;
    byte_en_t mem_byte_en;
    logic     ecall;
    logic     illegal_instruction;
    logic     test_done;
    int       error_count;
    int       seed;

    // per test the program, the expected stores in order and the end event
    instr_t            prog [num_tests][prog_words];
    xlen_t [0:3]       exp_addr [num_tests];
    byte_en_t [0:3]    exp_be [num_tests];
    xlen_t [0:3]       exp_data [num_tests];
    int                exp_count [num_tests];
    logic              exp_illegal [num_tests];
    xlen_t [0:3]       cur_addr = '0;
    byte_en_t [0:3]    cur_be = '0;
    xlen_t [0:3]       cur_data = '0;
    int                cur_count = 0;
    logic              cur_illegal = 1'b0;

    xlen_t      mem [256];
    logic [7:0] word_idx;
    int         phase = 0;
    int         delay;

    rv_core_top dut (
        .clock               (clock),
        .reset               (reset),
        .mem_busy            (mem_busy),
        .mem_rdata           (mem_rdata),
        .mem_addr            (mem_addr),
        .mem_wdata           (mem_wdata),
        .mem_rd_en           (mem_rd_en),
        .mem_wr_en           (mem_wr_en),
        .mem_byte_en         (mem_byte_en),
        .ecall               (ecall),
        .illegal_instruction (illegal_instruction)
    );

    rv_core_checker u_checker (
        .clock               (clock),
        .reset               (reset),
        .mem_wr_en           (mem_wr_en),
        .mem_addr            (mem_addr),
        .mem_byte_en         (mem_byte_en),
        .mem_wdata           (mem_wdata),
        .ecall               (ecall),
        .illegal_instruction (illegal_instruction),
        .exp_addr            (cur_addr),
        .exp_be              (cur_be),
        .exp_data            (cur_data),
        .exp_count           (cur_count),
        .exp_illegal         (cur_illegal),
        .test_done           (test_done),
        .error_count         (error_count)
    );

    initial begin
        forever #(clock_period / 2) clock = ~clock;
    end

    function automatic instr_t itype(input int imm, input int rs1, input int f3,
                                     input int rd, input opcode_t op);
        itype = {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic instr_t rtype(input int f7, input int rs2, input int rs1,
                                     input int f3, input int rd);
        rtype = {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op_reg};
    endfunction

    function automatic instr_t stype(input int imm, input int rs2, input int rs1, input int f3);
        stype = {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], op_store};
    endfunction

    function automatic instr_t btype(input int imm, input int rs2, input int rs1, input int f3);
        btype = {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                 op_branch};
    endfunction

    function automatic instr_t utype(input int imm20, input int rd, input opcode_t op);
        utype = {imm20[19:0], rd[4:0], op};
    endfunction

    function automatic instr_t jtype(input int imm, input int rd);
        jtype = {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], op_jal};
    endfunction

    task automatic fill_table();
        // sub, slt, sltu and add on -5 and 3
        prog[0] = '{itype(-5, 0, 0, 1, op_imm), itype(3, 0, 0, 2, op_imm),
                    rtype(32, 2, 1, 0, 3), rtype(0, 2, 1, 2, 4), rtype(0, 2, 1, 3, 5),
                    rtype(0, 2, 1, 0, 6), stype(512, 3, 0, 2), stype(516, 4, 0, 2),
                    stype(520, 5, 0, 2), stype(524, 6, 0, 2), ecall_word, 0};
        exp_addr[0] = '{32'h200, 32'h204, 32'h208, 32'h20c};
        exp_be[0] = '{4'hf, 4'hf, 4'hf, 4'hf};
        exp_data[0] = '{32'hffff_fff8, 32'h1, 32'h0, 32'hffff_fffe};
        // lui, auipc, sll, sra
        prog[1] = '{utype(20'h12345, 1, op_lui), itype(12'h678, 1, 0, 1, op_imm),
                    utype(1, 2, op_auipc), itype(4, 0, 0, 3, op_imm), rtype(0, 3, 1, 1, 4),
                    utype(20'h80000, 6, op_lui), rtype(32, 3, 6, 5, 7),
                    stype(512, 1, 0, 2), stype(516, 2, 0, 2), stype(520, 4, 0, 2),
                    stype(524, 7, 0, 2), ecall_word};
        exp_addr[1] = '{32'h200, 32'h204, 32'h208, 32'h20c};
        exp_be[1] = '{4'hf, 4'hf, 4'hf, 4'hf};
        exp_data[1] = '{32'h1234_5678, 32'h0000_1008, 32'h2345_6780, 32'hf800_0000};
        // or, and, xor, srli
        prog[2] = '{itype(240, 0, 0, 1, op_imm), itype(60, 0, 0, 2, op_imm),
                    rtype(0, 2, 1, 6, 3), rtype(0, 2, 1, 7, 4), rtype(0, 2, 1, 4, 5),
                    itype(-16, 0, 0, 7, op_imm), itype(4, 7, 5, 8, op_imm),
                    stype(512, 3, 0, 2), stype(516, 4, 0, 2), stype(520, 5, 0, 2),
                    stype(524, 8, 0, 2), ecall_word};
        exp_addr[2] = '{32'h200, 32'h204, 32'h208, 32'h20c};
        exp_be[2] = '{4'hf, 4'hf, 4'hf, 4'hf};
        exp_data[2] = '{32'hfc, 32'h30, 32'hcc, 32'h0fff_ffff};
        // beq not taken, bne taken, blt taken, bge not taken
        prog[3] = '{itype(-1, 0, 0, 1, op_imm), itype(1, 0, 0, 2, op_imm),
                    btype(8, 2, 1, 0), stype(512, 1, 0, 2), btype(8, 2, 1, 1),
                    stype(516, 1, 0, 2), btype(8, 2, 1, 4), stype(520, 1, 0, 2),
                    btype(8, 2, 1, 5), stype(524, 2, 0, 2), ecall_word, 0};
        exp_addr[3] = '{32'h200, 32'h20c, 32'h0, 32'h0};
        exp_be[3] = '{4'hf, 4'hf, 4'h0, 4'h0};
        exp_data[3] = '{32'hffff_ffff, 32'h1, 32'h0, 32'h0};
        // bltu not taken, bgeu taken, beq taken, bne not taken
        prog[4] = '{itype(-1, 0, 0, 1, op_imm), itype(1, 0, 0, 2, op_imm),
                    btype(8, 2, 1, 6), stype(512, 2, 0, 2), btype(8, 2, 1, 7),
                    stype(516, 2, 0, 2), btype(8, 2, 2, 0), stype(520, 1, 0, 2),
                    btype(8, 2, 2, 1), stype(524, 1, 0, 2), ecall_word, 0};
        exp_addr[4] = '{32'h200, 32'h20c, 32'h0, 32'h0};
        exp_be[4] = '{4'hf, 4'hf, 4'h0, 4'h0};
        exp_data[4] = '{32'h1, 32'hffff_ffff, 32'h0, 32'h0};
        // jal and jalr with an odd target, return addresses stored
        prog[5] = '{jtype(8, 3), stype(512, 0, 0, 2), stype(516, 3, 0, 2),
                    itype(25, 0, 0, 4, op_imm), itype(0, 4, 0, 5, op_jalr),
                    stype(520, 0, 0, 2), stype(524, 5, 0, 2), ecall_word, 0, 0, 0, 0};
        exp_addr[5] = '{32'h204, 32'h20c, 32'h0, 32'h0};
        exp_be[5] = '{4'hf, 4'hf, 4'h0, 4'h0};
        exp_data[5] = '{32'h4, 32'h14, 32'h0, 32'h0};
        // sb, sh, sw on 0x89abcdef in different lanes
        prog[6] = '{utype(20'h89abd, 1, op_lui), itype(-529, 1, 0, 1, op_imm),
                    stype(513, 1, 0, 0), stype(518, 1, 0, 1), stype(520, 1, 0, 2),
                    stype(515, 1, 0, 0), ecall_word, 0, 0, 0, 0, 0};
        exp_addr[6] = '{32'h200, 32'h204, 32'h208, 32'h200};
        exp_be[6] = '{4'h2, 4'hc, 4'hf, 4'h8};
        exp_data[6] = '{32'hefef_efef, 32'hcdef_cdef, 32'h89ab_cdef, 32'hefef_efef};
        // lb, lbu, lh, lhu from the data word at 0x2c
        prog[7] = '{itype(44, 0, 0, 1, op_load), itype(44, 0, 4, 2, op_load),
                    itype(46, 0, 1, 3, op_load), itype(46, 0, 5, 4, op_load),
                    stype(512, 1, 0, 2), stype(516, 2, 0, 2), stype(520, 3, 0, 2),
                    stype(524, 4, 0, 2), ecall_word, 0, 0, 32'h80f1_7f85};
        exp_addr[7] = '{32'h200, 32'h204, 32'h208, 32'h20c};
        exp_be[7] = '{4'hf, 4'hf, 4'hf, 4'hf};
        exp_data[7] = '{32'hffff_ff85, 32'h85, 32'hffff_80f1, 32'h80f1};
        // lw, lb, lh, then an opcode with low bits 00
        prog[8] = '{itype(44, 0, 2, 1, op_load), itype(45, 0, 0, 2, op_load),
                    itype(44, 0, 1, 3, op_load), stype(512, 1, 0, 2), stype(516, 2, 0, 2),
                    stype(520, 3, 0, 2), 32'h0000_0010, stype(524, 1, 0, 2),
                    0, 0, 0, 32'h80f1_7f85};
        exp_addr[8] = '{32'h200, 32'h204, 32'h208, 32'h0};
        exp_be[8] = '{4'hf, 4'hf, 4'hf, 4'h0};
        exp_data[8] = '{32'h80f1_7f85, 32'h7f, 32'h7f85, 32'h0};
        exp_count = '{4, 4, 4, 2, 2, 2, 4, 4, 3};
        exp_illegal = '{0, 0, 0, 0, 0, 0, 0, 0, 1};
    endtask

    task automatic load_memory(input int t);
        for (int i = 0; i < 256; i++) begin
            if (i < prog_words) begin
                mem[i] = prog[t][i];
            end else begin
                mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3};
            end
        end
    endtask

    assign word_idx = mem_addr[9:2];

    // random wait, then busy for 1 to 3 cycles with data as busy falls
    always @(posedge clock) begin
        if (reset) begin
            mem_busy <= 1'b0;
            phase    <= 0;
        end else begin
            case (phase)
                0: if (mem_rd_en || mem_wr_en) begin
                    delay <= $urandom_range(3, 0);
                    phase <= 1;
                end
                1: if (delay == 0) begin
                    mem_busy <= 1'b1;
                    delay    <= $urandom_range(2, 0);
                    phase    <= 2;
                end else begin
                    delay <= delay - 1;
                end
                2: if (delay == 0) begin
                    mem_busy  <= 1'b0;
                    mem_rdata <= mem[word_idx];
                    for (int b = 0; b < 4; b++) begin
                        if (mem_wr_en && mem_byte_en[b]) begin
                            mem[word_idx][8*b +: 8] <= mem_wdata[8*b +: 8];
                        end
                    end
                    phase <= 3;
                end else begin
                    delay <= delay - 1;
                end
                // core sees busy low here and drops its strobe
                default: phase <= 0;
            endcase
        end
    end

    initial begin
        #(num_tests * prog_words * 40 * clock_period);
        $display("watchdog expired before all tests finished");
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        seed = $urandom(32'h0461_c278);
        fill_table();
        for (int t = 0; t < num_tests; t++) begin
            @(posedge clock);
            reset <= 1'b1;
            @(posedge clock);
            load_memory(t);
            cur_addr    <= exp_addr[t];
            cur_be      <= exp_be[t];
            cur_data    <= exp_data[t];
            cur_count   <= exp_count[t];
            cur_illegal <= exp_illegal[t];
            repeat (3) @(posedge clock);
            reset <= 1'b0;
            @(posedge clock);
            while (!test_done) begin
                @(posedge clock);
            end
        end
        $display("%0d errors over %0d tests", error_count, num_tests);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
